// ==== logic/bp_defines.svh ====
/*
  size macros for the branch direction predictor
  index and history widths, buffer depth, lookup ports, threads
*/
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

`define GHT_IDX_W      13  // counter table index
`define GHT_HIST_W     13  // retired history per thread
`define GHT_CAM_DEPTH  32  // recently trained indices kept
`define GHT_PORTS      4   // lookups per fetch bundle
`define GHT_THREADS    2
`define GHT_PC_W       32

// index hash takes PC bits GHT_IDX_W+1 down to 2

`endif

// ==== logic/bp_pkg.sv ====
/*
  predictor types
  2-bit saturating counter and thread id
*/
`default_nettype none

package bp_pkg;

  // upper bit is the predicted direction
  typedef enum logic [1:0] {
    CTR_SNT = 2'b00,  // strong not-taken
    CTR_WNT = 2'b01,  // weak not-taken, reset state
    CTR_WT  = 2'b10,  // weak taken
    CTR_ST  = 2'b11   // strong taken
  } ctr_t;

  typedef logic thread_t;

endpackage

`default_nettype wire

// ==== logic/ght_buf.sv ====
/*
  one recently-trained-index entry
  index, owning thread, free flag, four compare ports
*/
`timescale 1ns/100ps
`default_nettype none
`include "bp_defines.svh"

module ght_buf import bp_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic [`GHT_IDX_W-1:0] addr0,
  input  wire logic [`GHT_IDX_W-1:0] addr1,
  input  wire logic [`GHT_IDX_W-1:0] addr2,
  input  wire logic [`GHT_IDX_W-1:0] addr3,
  output logic                       hit0,
  output logic                       hit1,
  output logic                       hit2,
  output logic                       hit3,
  input  wire logic                  wen,
  input  wire logic [`GHT_IDX_W-1:0] waddr,
  input  wire thread_t               wthread,
  input  wire logic                  except,
  input  wire thread_t               except_thread
);

  logic                  free;
  thread_t               thread;
  logic [`GHT_IDX_W-1:0] addr;
  thread_t               next_thread;  // owner after this edge

  assign next_thread = wen ? wthread : thread;

  assign hit0 = !free && (addr0 == addr);
  assign hit1 = !free && (addr1 == addr);
  assign hit2 = !free && (addr2 == addr);
  assign hit3 = !free && (addr3 == addr);

  always_ff @(posedge clk) begin
    if (rst) begin
      free <= 1'b1;
    end else if (except && (except_thread == next_thread)) begin
      free <= 1'b1;  // flush beats a same-thread write
    end else if (wen) begin
      free <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wen) begin
      addr   <= waddr;
      thread <= wthread;
    end
  end

endmodule

`default_nettype wire

// ==== logic/ght_cam.sv ====
/*
  buffer of the indices trained by the last GHT_CAM_DEPTH updates
  rotating one-hot write pointer, per-port hit OR, thread flush
*/
`timescale 1ns/100ps
`default_nettype none
`include "bp_defines.svh"

module ght_cam import bp_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic [`GHT_IDX_W-1:0] addr0,
  input  wire logic [`GHT_IDX_W-1:0] addr1,
  input  wire logic [`GHT_IDX_W-1:0] addr2,
  input  wire logic [`GHT_IDX_W-1:0] addr3,
  output logic                       hit0,
  output logic                       hit1,
  output logic                       hit2,
  output logic                       hit3,
  input  wire logic                  wen,
  input  wire logic [`GHT_IDX_W-1:0] waddr,
  input  wire thread_t               wthread,
  input  wire logic                  except,
  input  wire thread_t               except_thread
);

  localparam int DEPTH = `GHT_CAM_DEPTH;

  logic [DEPTH-1:0] wr_ptr;                 // oldest entry, next to overwrite
  logic [DEPTH-1:0] hit_way [`GHT_PORTS];   // per port, per entry

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // entries
  for (genvar e = 0; e < DEPTH; e++) begin : g_ent
    ght_buf buf0 (
      .clk           (clk),
      .rst           (rst),
      .addr0         (addr0),
      .addr1         (addr1),
      .addr2         (addr2),
      .addr3         (addr3),
      .hit0          (hit_way[0][e]),
      .hit1          (hit_way[1][e]),
      .hit2          (hit_way[2][e]),
      .hit3          (hit_way[3][e]),
      .wen           (wen && wr_ptr[e]),
      .waddr         (waddr),
      .wthread       (wthread),
      .except        (except),
      .except_thread (except_thread)
    );
  end

  assign hit0 = |hit_way[0];
  assign hit1 = |hit_way[1];
  assign hit2 = |hit_way[2];
  assign hit3 = |hit_way[3];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= DEPTH'(1);
    end else if (wen) begin
      wr_ptr <= {wr_ptr[DEPTH-2:0], wr_ptr[DEPTH-1]};  // rotate left
    end
  end

  // a lost or doubled bit would leave entries unwritten or written twice
  a_ptr_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(wr_ptr));

endmodule

`default_nettype wire

// ==== logic/ght_hist.sv ====
/*
  retired global history of each thread
  lookup and update index hashes
*/
`timescale 1ns/100ps
`default_nettype none
`include "bp_defines.svh"

module ght_hist import bp_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire thread_t               lookup_thread,
  input  wire logic [`GHT_PC_W-1:0]  pc0,
  input  wire logic [`GHT_PC_W-1:0]  pc1,
  input  wire logic [`GHT_PC_W-1:0]  pc2,
  input  wire logic [`GHT_PC_W-1:0]  pc3,
  output logic [`GHT_IDX_W-1:0]      idx0,
  output logic [`GHT_IDX_W-1:0]      idx1,
  output logic [`GHT_IDX_W-1:0]      idx2,
  output logic [`GHT_IDX_W-1:0]      idx3,
  input  wire thread_t               upd_thread,
  input  wire logic [`GHT_PC_W-1:0]  upd_pc,
  output logic [`GHT_IDX_W-1:0]      upd_idx,
  input  wire logic                  shift,
  input  wire thread_t               shift_thread,
  input  wire logic                  shift_taken
);

  logic [`GHT_HIST_W-1:0] hist [`GHT_THREADS];

  // pc word bits folded with the history
  function automatic logic [`GHT_IDX_W-1:0] hash(input logic [`GHT_PC_W-1:0] pc,
                                                 input logic [`GHT_HIST_W-1:0] h);
    return pc[`GHT_IDX_W+1:2] ^ h;
  endfunction

  assign idx0    = hash(pc0, hist[lookup_thread]);
  assign idx1    = hash(pc1, hist[lookup_thread]);
  assign idx2    = hash(pc2, hist[lookup_thread]);
  assign idx3    = hash(pc3, hist[lookup_thread]);
  assign upd_idx = hash(upd_pc, hist[upd_thread]);  // own thread's history

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < `GHT_THREADS; t++) hist[t] <= '0;
    end else if (shift) begin
      hist[shift_thread] <= {hist[shift_thread][`GHT_HIST_W-2:0], shift_taken};
    end
  end

endmodule

`default_nettype wire

// ==== logic/ght_table.sv ====
/*
  2-bit counter array
  four lookup read ports, one update read port, one write port
*/
`timescale 1ns/100ps
`default_nettype none
`include "bp_defines.svh"

module ght_table import bp_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic [`GHT_IDX_W-1:0] ridx0,
  input  wire logic [`GHT_IDX_W-1:0] ridx1,
  input  wire logic [`GHT_IDX_W-1:0] ridx2,
  input  wire logic [`GHT_IDX_W-1:0] ridx3,
  output ctr_t                       rctr0,
  output ctr_t                       rctr1,
  output ctr_t                       rctr2,
  output ctr_t                       rctr3,
  input  wire logic [`GHT_IDX_W-1:0] uidx,
  output ctr_t                       uctr,
  input  wire logic                  wen,
  input  wire logic [`GHT_IDX_W-1:0] widx,
  input  wire ctr_t                  wctr
);

  localparam int ENTRIES = 1 << `GHT_IDX_W;  // 8192 counters

  ctr_t ctr_mem [ENTRIES];
  ctr_t wold;  // counter about to be replaced

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reads, all combinational
  assign rctr0 = ctr_mem[ridx0];
  assign rctr1 = ctr_mem[ridx1];
  assign rctr2 = ctr_mem[ridx2];
  assign rctr3 = ctr_mem[ridx3];
  assign uctr  = ctr_mem[uidx];   // update controller
  assign wold  = ctr_mem[widx];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write port
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ENTRIES; i++) ctr_mem[i] <= CTR_WNT;  // weak not-taken
    end else if (wen) begin
      ctr_mem[widx] <= wctr;
    end
  end

  // a write moves the counter one step, or holds it at a saturated end
  a_wctr_legal: assert property (@(posedge clk) disable iff (rst)
    wen |-> (wctr == ctr_t'(wold + 2'd1) && wold != CTR_ST) ||
            (wctr == ctr_t'(wold - 2'd1) && wold != CTR_SNT) ||
            (wctr == wold && wold inside {CTR_SNT, CTR_ST}));

endmodule

`default_nettype wire

// ==== logic/ght_update.sv ====
/*
  four-phase update controller
  counter read, saturation, write-back, buffer insert, history shift
*/
`timescale 1ns/100ps
`default_nettype none
`include "bp_defines.svh"

module ght_update import bp_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  upd_req,
  output logic                       upd_ack,
  input  wire thread_t               upd_thread,
  input  wire logic                  upd_taken,
  input  wire logic [`GHT_IDX_W-1:0] upd_idx,
  output logic [`GHT_IDX_W-1:0]      uidx,
  input  wire ctr_t                  uctr,
  output logic                       tbl_wen,
  output logic [`GHT_IDX_W-1:0]      tbl_widx,
  output ctr_t                       tbl_wctr,
  output logic                       cam_wen,
  output logic [`GHT_IDX_W-1:0]      cam_addr,
  output thread_t                    cam_thread,
  output logic                       hist_shift,
  output thread_t                    hist_thread,
  output logic                       hist_taken
);

  typedef enum logic [1:0] {S_IDLE, S_READ, S_WRITE, S_WAIT} state_t;

  state_t                state;
  logic [`GHT_IDX_W-1:0] idx_q;    // latched on acceptance
  thread_t               thread_q;
  logic                  taken_q;
  ctr_t                  wctr_q;   // saturated value for write-back

  function automatic ctr_t sat_ctr(input ctr_t c, input logic taken);
    if (taken) return (c == CTR_ST) ? CTR_ST : ctr_t'(c + 2'd1);
    return (c == CTR_SNT) ? CTR_SNT : ctr_t'(c - 2'd1);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // FSM and ack
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_IDLE;
      upd_ack <= 1'b0;
    end else begin
      case (state)
        S_IDLE:  if (upd_req) state <= S_READ;
        S_READ: begin
          state   <= S_WRITE;
          upd_ack <= 1'b1;      // high along with the write
        end
        S_WRITE: state <= S_WAIT;
        S_WAIT: begin
          if (!upd_req) begin   // release seen, drop ack next cycle
            state   <= S_IDLE;
            upd_ack <= 1'b0;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && upd_req) begin
      idx_q    <= upd_idx;
      thread_q <= upd_thread;
      taken_q  <= upd_taken;
    end
    if (state == S_READ) wctr_q <= sat_ctr(uctr, taken_q);
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // single-cycle commit in S_WRITE
  assign uidx        = idx_q;
  assign tbl_wen     = (state == S_WRITE);
  assign tbl_widx    = idx_q;
  assign tbl_wctr    = wctr_q;
  assign cam_wen     = (state == S_WRITE);
  assign cam_addr    = idx_q;
  assign cam_thread  = thread_q;
  assign hist_shift  = (state == S_WRITE);
  assign hist_thread = thread_q;
  assign hist_taken  = taken_q;

  // four-phase rule, ack is held for as long as the request is
  a_ack_hold: assert property (@(posedge clk) disable iff (rst)
    upd_ack && upd_req |=> upd_ack);

endmodule

`default_nettype wire

// ==== logic/ght_predictor.sv ====
/*
  branch direction predictor top level
  lookup output register, update and exception wiring
*/
`timescale 1ns/100ps
`default_nettype none
`include "bp_defines.svh"

module ght_predictor import bp_pkg::*; (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 lookup_valid,
  input  wire thread_t              lookup_thread,
  input  wire logic [`GHT_PC_W-1:0] pc0,
  input  wire logic [`GHT_PC_W-1:0] pc1,
  input  wire logic [`GHT_PC_W-1:0] pc2,
  input  wire logic [`GHT_PC_W-1:0] pc3,
  output logic                      pred_valid,
  output logic                      pred_taken0,
  output logic                      pred_taken1,
  output logic                      pred_taken2,
  output logic                      pred_taken3,
  output logic                      pred_stale0,
  output logic                      pred_stale1,
  output logic                      pred_stale2,
  output logic                      pred_stale3,
  input  wire logic                 upd_req,
  output logic                      upd_ack,
  input  wire thread_t              upd_thread,
  input  wire logic [`GHT_PC_W-1:0] upd_pc,
  input  wire logic                 upd_taken,
  input  wire logic                 except,
  input  wire thread_t              except_thread
);

  logic [`GHT_IDX_W-1:0] idx0, idx1, idx2, idx3;
  logic [`GHT_IDX_W-1:0] upd_idx, uidx, tbl_widx, cam_addr;
  ctr_t                  rctr0, rctr1, rctr2, rctr3, uctr, tbl_wctr;
  logic                  hit0, hit1, hit2, hit3;
  logic                  tbl_wen, cam_wen, hist_shift, hist_taken;
  thread_t               cam_thread, hist_thread;

  ght_hist hist0 (
    .clk(clk), .rst(rst), .lookup_thread(lookup_thread),
    .pc0(pc0), .pc1(pc1), .pc2(pc2), .pc3(pc3),
    .idx0(idx0), .idx1(idx1), .idx2(idx2), .idx3(idx3),
    .upd_thread(upd_thread), .upd_pc(upd_pc), .upd_idx(upd_idx),
    .shift(hist_shift), .shift_thread(hist_thread), .shift_taken(hist_taken)
  );

  ght_table table0 (
    .clk(clk), .rst(rst),
    .ridx0(idx0), .ridx1(idx1), .ridx2(idx2), .ridx3(idx3),
    .rctr0(rctr0), .rctr1(rctr1), .rctr2(rctr2), .rctr3(rctr3),
    .uidx(uidx), .uctr(uctr), .wen(tbl_wen), .widx(tbl_widx), .wctr(tbl_wctr)
  );

  ght_cam cam0 (
    .clk(clk), .rst(rst),
    .addr0(idx0), .addr1(idx1), .addr2(idx2), .addr3(idx3),
    .hit0(hit0), .hit1(hit1), .hit2(hit2), .hit3(hit3),
    .wen(cam_wen), .waddr(cam_addr), .wthread(cam_thread),
    .except(except), .except_thread(except_thread)   // flush goes straight in
  );

  ght_update upd0 (
    .clk(clk), .rst(rst), .upd_req(upd_req), .upd_ack(upd_ack),
    .upd_thread(upd_thread), .upd_taken(upd_taken), .upd_idx(upd_idx),
    .uidx(uidx), .uctr(uctr),
    .tbl_wen(tbl_wen), .tbl_widx(tbl_widx), .tbl_wctr(tbl_wctr),
    .cam_wen(cam_wen), .cam_addr(cam_addr), .cam_thread(cam_thread),
    .hist_shift(hist_shift), .hist_thread(hist_thread), .hist_taken(hist_taken)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // lookup results, one cycle after lookup_valid
  always_ff @(posedge clk) begin
    if (rst) pred_valid <= 1'b0;
    else     pred_valid <= lookup_valid;
  end

  always_ff @(posedge clk) begin
    if (lookup_valid) begin
      pred_taken0 <= rctr0[1];  // counter msb is the direction
      pred_taken1 <= rctr1[1];
      pred_taken2 <= rctr2[1];
      pred_taken3 <= rctr3[1];
      pred_stale0 <= hit0;
      pred_stale1 <= hit1;
      pred_stale2 <= hit2;
      pred_stale3 <= hit3;
    end
  end

endmodule

`default_nettype wire

// ==== verification/ght_predictor_tb.sv ====
/*
  testbench for the branch direction predictor
  LFSR stimulus, reference model of histories, counters and trained-index list
  lookup, four-phase update and exception checks
*/
`timescale 1ns/100ps
`default_nettype none
`include "bp_defines.svh"

module ght_predictor_tb;

  localparam int SLOTS = `GHT_CAM_DEPTH;

  logic                 clk;
  logic                 rst;
  logic                 lookup_valid;
  logic                 lookup_thread;
  logic [`GHT_PC_W-1:0] pc0, pc1, pc2, pc3;
  logic                 pred_valid;
  logic                 pred_taken0, pred_taken1, pred_taken2, pred_taken3;
  logic                 pred_stale0, pred_stale1, pred_stale2, pred_stale3;
  logic                 upd_req;
  logic                 upd_ack;
  logic                 upd_thread;
  logic [`GHT_PC_W-1:0] upd_pc;
  logic                 upd_taken;
  logic                 except;
  logic                 except_thread;

  // reference model
  logic [`GHT_HIST_W-1:0] hist_m [`GHT_THREADS];
  logic [1:0]             ctr_m [1 << `GHT_IDX_W];
  logic [`GHT_IDX_W-1:0]  slot_idx [SLOTS];
  logic                   slot_thr [SLOTS];
  logic                   slot_vld [SLOTS];
  logic [4:0]             slot_ptr;  // oldest slot
  logic [`GHT_IDX_W-1:0]  aged_idx;  // index that last left the list
  logic [15:0]            lfsr;

  ght_predictor dut0 (
    .clk(clk), .rst(rst), .lookup_valid(lookup_valid), .lookup_thread(lookup_thread),
    .pc0(pc0), .pc1(pc1), .pc2(pc2), .pc3(pc3), .pred_valid(pred_valid),
    .pred_taken0(pred_taken0), .pred_taken1(pred_taken1),
    .pred_taken2(pred_taken2), .pred_taken3(pred_taken3),
    .pred_stale0(pred_stale0), .pred_stale1(pred_stale1),
    .pred_stale2(pred_stale2), .pred_stale3(pred_stale3),
    .upd_req(upd_req), .upd_ack(upd_ack), .upd_thread(upd_thread),
    .upd_pc(upd_pc), .upd_taken(upd_taken),
    .except(except), .except_thread(except_thread)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // random bits and checks
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s within 20 cycles", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "wait timed out");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  function automatic logic [`GHT_IDX_W-1:0] model_idx(input logic [31:0] pc,
                                                      input logic thr);
    return pc[`GHT_IDX_W+1:2] ^ hist_m[thr];
  endfunction

  function automatic logic model_stale(input logic [`GHT_IDX_W-1:0] idx);
    logic hit;
    hit = 1'b0;
    for (int s = 0; s < SLOTS; s++) begin
      if (slot_vld[s] && slot_idx[s] == idx) hit = 1'b1;
    end
    return hit;
  endfunction

  task automatic model_reset();
    for (int t = 0; t < `GHT_THREADS; t++) hist_m[t] = '0;
    for (int i = 0; i < (1 << `GHT_IDX_W); i++) ctr_m[i] = 2'b01;  // weak not-taken
    for (int s = 0; s < SLOTS; s++) begin
      slot_idx[s] = '0;
      slot_thr[s] = 1'b0;
      slot_vld[s] = 1'b0;
    end
    slot_ptr = '0;
    aged_idx = '0;
  endtask

  task automatic model_update(input logic thr, input logic [31:0] pc, input logic taken);
    logic [`GHT_IDX_W-1:0] idx;
    idx = model_idx(pc, thr);
    if (taken && ctr_m[idx] != 2'd3) ctr_m[idx] = ctr_m[idx] + 2'd1;
    else if (!taken && ctr_m[idx] != 2'd0) ctr_m[idx] = ctr_m[idx] - 2'd1;
    aged_idx = slot_idx[slot_ptr];
    slot_idx[slot_ptr] = idx;  // oldest slot is overwritten
    slot_thr[slot_ptr] = thr;
    slot_vld[slot_ptr] = 1'b1;
    slot_ptr = slot_ptr + 5'd1;
    hist_m[thr] = {hist_m[thr][`GHT_HIST_W-2:0], taken};
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // pc from a small pool, or aimed at a trained index under thr's history
  task automatic pick_pc(input logic thr, input logic aim, output logic [31:0] pc);
    logic [31:0] mode;
    logic [31:0] r;
    take_bits(2, mode);
    if (aim || mode == 0) begin
      take_bits(5, r);
      pc = 32'({slot_idx[r[4:0]] ^ hist_m[thr], 2'b00});
    end else begin
      take_bits(4, r);
      pc = 32'h0040_0000 | 32'({r[3:0], 2'b00});  // bit 22 is outside the hash
    end
  endtask

  task automatic run_lookup(input logic thr, input logic [31:0] p0, input logic [31:0] p1,
                            input logic [31:0] p2, input logic [31:0] p3);
    logic [31:0]           pcs [4];
    logic [3:0]            exp_taken;
    logic [3:0]            exp_stale;
    logic [`GHT_IDX_W-1:0] idx;
    pcs[0] = p0;
    pcs[1] = p1;
    pcs[2] = p2;
    pcs[3] = p3;
    for (int p = 0; p < 4; p++) begin
      idx = model_idx(pcs[p], thr);
      exp_taken[p] = ctr_m[idx][1];
      exp_stale[p] = model_stale(idx);
    end
    @(posedge clk);
    lookup_valid  <= 1'b1;
    lookup_thread <= thr;
    pc0 <= p0;
    pc1 <= p1;
    pc2 <= p2;
    pc3 <= p3;
    @(negedge clk);
    check_value("pred_valid", 32'(pred_valid), 0);  // not yet
    @(posedge clk);
    lookup_valid <= 1'b0;
    @(negedge clk);
    check_value("pred_valid", 32'(pred_valid), 1);
    check_value("pred_taken", 32'({pred_taken3, pred_taken2, pred_taken1, pred_taken0}),
                32'(exp_taken));
    check_value("pred_stale", 32'({pred_stale3, pred_stale2, pred_stale1, pred_stale0}),
                32'(exp_stale));
  endtask

  task automatic random_lookup(input logic thr, input logic aim);
    logic [31:0] p [4];
    for (int i = 0; i < 4; i++) pick_pc(thr, aim, p[i]);
    run_lookup(thr, p[0], p[1], p[2], p[3]);
  endtask

  task automatic run_update(input logic thr, input logic [31:0] pc, input logic taken);
    int          n;
    logic [31:0] hold;
    logic [31:0] gap;
    take_bits(2, hold);
    take_bits(2, gap);
    @(posedge clk);
    upd_req    <= 1'b1;
    upd_thread <= thr;
    upd_pc     <= pc;
    upd_taken  <= taken;
    n = 0;
    @(negedge clk);
    while (!upd_ack && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!upd_ack) report_timeout("update acknowledge never arrived");
    check_value("upd_ack rise cycle", n, 2);
    for (int k = 0; k < hold; k++) begin  // ack held while req stays up
      @(negedge clk);
      check_value("upd_ack", 32'(upd_ack), 1);
    end
    @(posedge clk);
    upd_req <= 1'b0;
    n = 0;
    @(negedge clk);
    while (upd_ack && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (upd_ack) report_timeout("update acknowledge never dropped");
    check_value("upd_ack fall cycle", n, 1);
    model_update(thr, pc, taken);
    repeat (gap) @(posedge clk);  // idle gap before the next request
  endtask

  task automatic run_except(input logic thr);
    @(posedge clk);
    except        <= 1'b1;
    except_thread <= thr;
    @(posedge clk);
    except <= 1'b0;
    for (int s = 0; s < SLOTS; s++) begin
      if (slot_thr[s] == thr) slot_vld[s] = 1'b0;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence
  initial begin
    logic [31:0] r;
    logic [31:0] tk;
    logic [31:0] upc;
    logic [31:0] p [3];
    lfsr = 16'd26;
    model_reset();
    rst           <= 1'b1;
    lookup_valid  <= 1'b0;
    lookup_thread <= 1'b0;
    pc0           <= '0;
    pc1           <= '0;
    pc2           <= '0;
    pc3           <= '0;
    upd_req       <= 1'b0;
    upd_thread    <= 1'b0;
    upd_pc        <= '0;
    upd_taken     <= 1'b0;
    except        <= 1'b0;
    except_thread <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("upd_ack", 32'(upd_ack), 0);
    check_value("pred_valid", 32'(pred_valid), 0);

    for (int i = 0; i < 8; i++) begin  // fresh table, both threads
      take_bits(1, r);
      random_lookup(r[0], 1'b0);
    end

    for (int i = 0; i < 200; i++) begin
      take_bits(1, r);
      take_bits(1, tk);
      pick_pc(r[0], 1'b0, upc);
      run_update(r[0], upc, tk[0]);
      for (int k = 0; k < 2; k++) pick_pc(r[0], 1'b0, p[k]);
      p[2] = 32'({aged_idx ^ hist_m[r[0]], 2'b00});  // index that just aged out
      run_lookup(r[0], upc, p[0], p[1], p[2]);  // trained pc, own history
      for (int k = 0; k < 3; k++) begin
        take_bits(1, r);
        random_lookup(r[0], 1'b0);
      end
      take_bits(3, r);
      if (r[2:0] == 3'd0) begin
        take_bits(1, r);
        run_except(r[0]);
        random_lookup(r[0], 1'b1);   // flushed thread
        random_lookup(!r[0], 1'b1);  // other thread keeps its entries
      end
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+logic
logic/bp_pkg.sv
logic/ght_buf.sv
logic/ght_cam.sv
logic/ght_hist.sv
logic/ght_table.sv
logic/ght_update.sv
logic/ght_predictor.sv
verification/ght_predictor_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module ght_predictor_tb -f flist.f -o ght_sim

out=$(./obj_dir/ght_sim 2>&1 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"
